// ==== Makefile ====
TOOL     := verilator
TOP      := tb_bp_mc_bridge
FILELIST := filelist.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --assert --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM      := $(OBJ_DIR)/V$(TOP)
SIM_ARGS := +verilator+error+limit+100
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: compile
	-$(SIM) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/bp_io_pkg.sv ====
package bp_io_pkg;

  //////////////////////////////
  // address map
  //////////////////////////////

  localparam int BP_PADDR_WIDTH = 40;
  localparam int BP_DATA_WIDTH  = 64;

  // inbound device windows
  localparam logic [BP_PADDR_WIDTH-1:0] BP_CFG_BASE   = 40'h20_0000;
  localparam logic [BP_PADDR_WIDTH-1:0] BP_CLINT_BASE = 40'h30_0000;

  //////////////////////////////
  // message encodings
  //////////////////////////////

  // cached forms are handled as uncached
  typedef enum logic [1:0]
  {
    e_uc_rd = 2'b00,
    e_uc_wr = 2'b01,
    e_rd    = 2'b10,
    e_wr    = 2'b11
  } bp_msg_type_e;

  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } bp_msg_size_e;

  //////////////////////////////
  // messages
  //////////////////////////////

  typedef struct packed
  {
    bp_msg_type_e              msg_type;
    bp_msg_size_e              size;
    logic [BP_PADDR_WIDTH-1:0] addr;
  } bp_io_header_s;

  typedef struct packed
  {
    bp_io_header_s            header;
    logic [BP_DATA_WIDTH-1:0] data;
  } bp_io_msg_s;

endpackage

// ==== common/mc_net_pkg.sv ====
package mc_net_pkg;

  //////////////////////////////
  // mesh constants
  //////////////////////////////

  localparam int MC_DATA_WIDTH      = 32;
  // word address inside the target node
  localparam int MC_ADDR_WIDTH      = 28;
  localparam int MC_X_WIDTH         = 7;
  localparam int MC_POD_Y_WIDTH     = 4;
  localparam int MC_SUBCORD_Y_WIDTH = 3;
  localparam int MC_Y_WIDTH         = MC_POD_Y_WIDTH + MC_SUBCORD_Y_WIDTH;
  localparam int MC_TILE_ADDR_WIDTH = 18;

  // in-flight limit, sets the id width too
  localparam int MC_MAX_OUTSTANDING = 4;
  localparam int MC_ID_WIDTH        = 2;

  //////////////////////////////
  // encodings
  //////////////////////////////

  typedef enum logic
  {
    e_remote_load  = 1'b0,
    e_remote_store = 1'b1
  } mc_op_e;

  typedef enum logic [3:0]
  {
    e_dev_cfg   = 4'd0,
    e_dev_clint = 4'd1
  } mc_dev_e;

  //////////////////////////////
  // packets
  //////////////////////////////

  typedef struct packed
  {
    logic       is_byte;
    logic       is_hex;
    logic [1:0] part_sel;
  } mc_load_info_s;

  typedef struct packed
  {
    logic [MC_ADDR_WIDTH-1:0]   addr;
    mc_op_e                     op;
    logic [MC_ID_WIDTH-1:0]     reg_id;
    logic [MC_DATA_WIDTH-1:0]   payload;
    logic [MC_DATA_WIDTH/8-1:0] mask;
    mc_load_info_s              load_info;
    logic [MC_X_WIDTH-1:0]      src_x;
    logic [MC_Y_WIDTH-1:0]      src_y;
    logic [MC_X_WIDTH-1:0]      dst_x;
    logic [MC_Y_WIDTH-1:0]      dst_y;
  } mc_packet_s;

  typedef struct packed
  {
    logic [MC_ID_WIDTH-1:0]   reg_id;
    logic [MC_DATA_WIDTH-1:0] data;
  } mc_return_s;

  typedef struct packed
  {
    logic [MC_ADDR_WIDTH-1:0] addr;
    logic [MC_DATA_WIDTH-1:0] data;
    logic                     we;
  } mc_in_req_s;

  // low bits of an inbound request address
  typedef struct packed
  {
    mc_dev_e     dev;
    logic [11:0] addr;
  } mc_epa_s;

endpackage

// ==== filelist.f ====
common/bp_io_pkg.sv
common/mc_net_pkg.sv
hw/outbound/cmd_fifo.sv
hw/outbound/mc_packet_former.sv
hw/outbound/trans_tracker.sv
hw/bp_io_forwarder.sv
hw/bp_mc_bridge.sv
testbench/bp_mc_bridge_assert.sv
testbench/tb_bp_mc_bridge.sv

// ==== hw/bp_io_forwarder.sv ====
`timescale 1ns/1ps

module bp_io_forwarder
  (
    input  mc_net_pkg::mc_in_req_s               mc_in_i,
    input  logic                                 mc_in_v_i,
    output logic                                 mc_in_yumi_o,

    output bp_io_pkg::bp_io_msg_s                io_cmd_o,
    output logic                                 io_cmd_v_o,
    input  logic                                 io_cmd_yumi_i,

    input  bp_io_pkg::bp_io_msg_s                io_resp_i,
    input  logic                                 io_resp_v_i,

    output logic [mc_net_pkg::MC_DATA_WIDTH-1:0] mc_returning_data_o,
    output logic                                 mc_returning_v_o
  );

  mc_net_pkg::mc_epa_s                  epa;
  logic [bp_io_pkg::BP_PADDR_WIDTH-1:0] dev_base;

  //////////////////////////////
  // network request in
  //////////////////////////////

  assign epa      = mc_in_i.addr[$bits(mc_net_pkg::mc_epa_s)-1:0];
  // unknown devices fall back to cfg
  assign dev_base = (epa.dev == mc_net_pkg::e_dev_clint) ? bp_io_pkg::BP_CLINT_BASE
                                                         : bp_io_pkg::BP_CFG_BASE;

  always_comb
  begin
    io_cmd_o.header.msg_type = mc_in_i.we ? bp_io_pkg::e_uc_wr : bp_io_pkg::e_uc_rd;
    io_cmd_o.header.addr     = dev_base
                               + {{(bp_io_pkg::BP_PADDR_WIDTH - 12){1'b0}}, epa.addr};
    // 32-bit accesses only
    io_cmd_o.header.size     = bp_io_pkg::e_size_4;
    io_cmd_o.data            = {{(bp_io_pkg::BP_DATA_WIDTH - mc_net_pkg::MC_DATA_WIDTH){1'b0}},
                                mc_in_i.data};
  end

  // request waits while the processor stalls
  assign io_cmd_v_o   = mc_in_v_i;
  assign mc_in_yumi_o = io_cmd_yumi_i;

  //////////////////////////////
  // processor return out
  //////////////////////////////

  always_comb
  begin
    case (io_resp_i.header.size)
      bp_io_pkg::e_size_4: mc_returning_data_o = io_resp_i.data[31:0];
      bp_io_pkg::e_size_2: mc_returning_data_o = {16'h0, io_resp_i.data[15:0]};
      default:             mc_returning_data_o = {24'h0, io_resp_i.data[7:0]};
    endcase
  end

  assign mc_returning_v_o = io_resp_v_i;

endmodule

// ==== hw/bp_mc_bridge.sv ====
`timescale 1ns/1ps

module bp_mc_bridge
  (
    input  logic                                clk_i,
    input  logic                                arst_n_i,

    input  bp_io_pkg::bp_io_msg_s               io_cmd_i,
    input  logic                                io_cmd_v_i,
    output logic                                io_cmd_ready_o,

    output bp_io_pkg::bp_io_msg_s               io_resp_o,
    output logic                                io_resp_v_o,
    input  logic                                io_resp_yumi_i,

    output mc_net_pkg::mc_packet_s              mc_out_o,
    output logic                                mc_out_v_o,
    input  logic                                mc_out_ready_i,

    input  mc_net_pkg::mc_return_s              mc_return_i,
    input  logic                                mc_return_v_i,

    input  mc_net_pkg::mc_in_req_s              mc_in_i,
    input  logic                                mc_in_v_i,
    output logic                                mc_in_yumi_o,

    output bp_io_pkg::bp_io_msg_s               io_cmd_o,
    output logic                                io_cmd_v_o,
    input  logic                                io_cmd_yumi_i,

    input  bp_io_pkg::bp_io_msg_s               io_resp_i,
    input  logic                                io_resp_v_i,

    output logic [mc_net_pkg::MC_DATA_WIDTH-1:0] mc_returning_data_o,
    output logic                                mc_returning_v_o,

    input  logic [mc_net_pkg::MC_X_WIDTH-1:0]   my_x_i,
    input  logic [mc_net_pkg::MC_Y_WIDTH-1:0]   my_y_i
  );

  // fifo head towards the tracker
  bp_io_pkg::bp_io_msg_s               head_msg;
  logic                                head_v;
  logic                                head_yumi;
  logic [mc_net_pkg::MC_ID_WIDTH-1:0]  trans_id;

  //////////////////////////////
  // outbound path
  //////////////////////////////

  cmd_fifo i_cmd_fifo
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (io_cmd_i),
    .v_i      (io_cmd_v_i),
    .ready_o  (io_cmd_ready_o),
    .data_o   (head_msg),
    .v_o      (head_v),
    .yumi_i   (head_yumi)
  );

  trans_tracker i_trans_tracker
  (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cmd_v_i        (head_v),
    .cmd_header_i   (head_msg.header),
    .mc_out_ready_i (mc_out_ready_i),
    .mc_return_v_i  (mc_return_v_i),
    .mc_return_i    (mc_return_i),
    .io_resp_yumi_i (io_resp_yumi_i),
    .cmd_yumi_o     (head_yumi),
    .mc_out_v_o     (mc_out_v_o),
    .trans_id_o     (trans_id),
    .io_resp_o      (io_resp_o),
    .io_resp_v_o    (io_resp_v_o)
  );

  mc_packet_former i_mc_packet_former
  (
    .cmd_i      (head_msg),
    .trans_id_i (trans_id),
    .my_x_i     (my_x_i),
    .my_y_i     (my_y_i),
    .packet_o   (mc_out_o)
  );

  //////////////////////////////
  // inbound path
  //////////////////////////////

  bp_io_forwarder i_bp_io_forwarder
  (
    .mc_in_i             (mc_in_i),
    .mc_in_v_i           (mc_in_v_i),
    .io_cmd_yumi_i       (io_cmd_yumi_i),
    .io_resp_i           (io_resp_i),
    .io_resp_v_i         (io_resp_v_i),
    .mc_in_yumi_o        (mc_in_yumi_o),
    .io_cmd_o            (io_cmd_o),
    .io_cmd_v_o          (io_cmd_v_o),
    .mc_returning_data_o (mc_returning_data_o),
    .mc_returning_v_o    (mc_returning_v_o)
  );

endmodule

// ==== hw/outbound/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo
  (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    input  bp_io_pkg::bp_io_msg_s data_i,
    input  logic                  v_i,
    output logic                  ready_o,

    output bp_io_pkg::bp_io_msg_s data_o,
    output logic                  v_o,
    input  logic                  yumi_i
  );

  // storage, one slot per outstanding command
  bp_io_pkg::bp_io_msg_s mem_r [mc_net_pkg::MC_MAX_OUTSTANDING];

  logic [$clog2(mc_net_pkg::MC_MAX_OUTSTANDING)-1:0] wr_ptr_r;
  logic [$clog2(mc_net_pkg::MC_MAX_OUTSTANDING)-1:0] rd_ptr_r;
  logic [$clog2(mc_net_pkg::MC_MAX_OUTSTANDING):0]   count_r;

  logic push;
  logic pop;

  assign ready_o = (count_r != mc_net_pkg::MC_MAX_OUTSTANDING);
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= data_i;
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      if (push && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !push)
        count_r <= count_r - 1'b1;
    end
  end

endmodule

// ==== hw/outbound/mc_packet_former.sv ====
`timescale 1ns/1ps

module mc_packet_former
  (
    input  bp_io_pkg::bp_io_msg_s               cmd_i,
    input  logic [mc_net_pkg::MC_ID_WIDTH-1:0]  trans_id_i,
    input  logic [mc_net_pkg::MC_X_WIDTH-1:0]   my_x_i,
    input  logic [mc_net_pkg::MC_Y_WIDTH-1:0]   my_y_i,
    output mc_net_pkg::mc_packet_s              packet_o
  );

  logic [bp_io_pkg::BP_PADDR_WIDTH-1:0] addr;
  logic [1:0]                           region;

  logic [mc_net_pkg::MC_ADDR_WIDTH-1:0]      tile_addr;
  logic [mc_net_pkg::MC_X_WIDTH-1:0]         tile_x;
  logic [mc_net_pkg::MC_Y_WIDTH-1:0]         tile_y;

  logic [mc_net_pkg::MC_ADDR_WIDTH-1:0]      vc_addr;
  logic [mc_net_pkg::MC_X_WIDTH-1:0]         vc_x;
  logic [mc_net_pkg::MC_POD_Y_WIDTH-1:0]     vc_pod_y;
  logic [mc_net_pkg::MC_SUBCORD_Y_WIDTH-1:0] vc_sub_y;

  logic [3:0]                                mask_base;

  assign addr   = cmd_i.header.addr;
  assign region = addr[bp_io_pkg::BP_PADDR_WIDTH-1 -: 2];

  //////////////////////////////
  // tile fields
  //////////////////////////////

  assign tile_addr = {{(mc_net_pkg::MC_ADDR_WIDTH - mc_net_pkg::MC_TILE_ADDR_WIDTH){1'b0}},
                      addr[2 +: mc_net_pkg::MC_TILE_ADDR_WIDTH]};
  assign tile_x    = addr[2 + mc_net_pkg::MC_TILE_ADDR_WIDTH +: mc_net_pkg::MC_X_WIDTH];
  assign tile_y    = addr[2 + mc_net_pkg::MC_TILE_ADDR_WIDTH + mc_net_pkg::MC_X_WIDTH
                          +: mc_net_pkg::MC_Y_WIDTH];

  //////////////////////////////
  // vcache fields
  //////////////////////////////

  // also the host epa
  assign vc_addr  = addr[2 +: mc_net_pkg::MC_ADDR_WIDTH];
  assign vc_x     = addr[2 + mc_net_pkg::MC_ADDR_WIDTH +: mc_net_pkg::MC_X_WIDTH];
  // vcache pods sit on even pod rows, 0 or 2
  assign vc_pod_y = {{(mc_net_pkg::MC_POD_Y_WIDTH - 2){1'b0}},
                     addr[2 + mc_net_pkg::MC_ADDR_WIDTH + mc_net_pkg::MC_X_WIDTH], 1'b0};
  // north row of pod 0 is the bottom edge
  assign vc_sub_y = (vc_pod_y == '0) ? '1 : '0;

  always_comb
  begin
    case (cmd_i.header.size)
      bp_io_pkg::e_size_1: mask_base = 4'h1;
      bp_io_pkg::e_size_2: mask_base = 4'h3;
      default:             mask_base = 4'hf;
    endcase
  end

  always_comb
  begin
    packet_o        = '0;
    packet_o.src_x  = my_x_i;
    packet_o.src_y  = my_y_i;
    packet_o.reg_id = trans_id_i;

    if (region == 2'b11)
    begin
      packet_o.addr  = tile_addr;
      packet_o.dst_x = tile_x;
      packet_o.dst_y = tile_y;
    end
    else if (region == 2'b10)
    begin
      packet_o.addr  = vc_addr;
      packet_o.dst_x = vc_x;
      packet_o.dst_y = {vc_pod_y, vc_sub_y};
    end
    else
    begin
      // host sits right above this link
      packet_o.addr  = vc_addr;
      packet_o.dst_x = '0;
      packet_o.dst_y = my_y_i - 1'b1;
    end

    case (cmd_i.header.msg_type)
      bp_io_pkg::e_uc_rd, bp_io_pkg::e_rd:
      begin
        packet_o.op                 = mc_net_pkg::e_remote_load;
        packet_o.load_info.is_byte  = (cmd_i.header.size == bp_io_pkg::e_size_1);
        packet_o.load_info.is_hex   = (cmd_i.header.size == bp_io_pkg::e_size_2);
        packet_o.load_info.part_sel = addr[1:0];
      end
      default:
      begin
        packet_o.op      = mc_net_pkg::e_remote_store;
        packet_o.payload = cmd_i.data[mc_net_pkg::MC_DATA_WIDTH-1:0];
        packet_o.mask    = mask_base << addr[1:0];
      end
    endcase
  end

endmodule

// ==== hw/outbound/trans_tracker.sv ====
`timescale 1ns/1ps

module trans_tracker
  (
    input  logic                                clk_i,
    input  logic                                arst_n_i,

    input  logic                                cmd_v_i,
    input  bp_io_pkg::bp_io_header_s            cmd_header_i,
    output logic                                cmd_yumi_o,

    output logic                                mc_out_v_o,
    input  logic                                mc_out_ready_i,
    output logic [mc_net_pkg::MC_ID_WIDTH-1:0]  trans_id_o,

    input  logic                                mc_return_v_i,
    input  mc_net_pkg::mc_return_s              mc_return_i,

    output bp_io_pkg::bp_io_msg_s               io_resp_o,
    output logic                                io_resp_v_o,
    input  logic                                io_resp_yumi_i
  );

  logic [mc_net_pkg::MC_ID_WIDTH-1:0] alloc_ptr_r;
  logic [mc_net_pkg::MC_ID_WIDTH-1:0] deq_ptr_r;
  logic [mc_net_pkg::MC_ID_WIDTH:0]   count_r;
  logic [mc_net_pkg::MC_MAX_OUTSTANDING-1:0] filled_r;

  // per-id copies of the issued header and the returned word
  bp_io_pkg::bp_io_header_s          header_r [mc_net_pkg::MC_MAX_OUTSTANDING];
  logic [mc_net_pkg::MC_DATA_WIDTH-1:0] data_r [mc_net_pkg::MC_MAX_OUTSTANDING];

  logic id_free;
  logic issue;
  logic deq;

  //////////////////////////////
  // issue side
  //////////////////////////////

  assign id_free    = (count_r != mc_net_pkg::MC_MAX_OUTSTANDING);
  assign mc_out_v_o = cmd_v_i & id_free;
  assign issue      = mc_out_v_o & mc_out_ready_i;
  assign cmd_yumi_o = issue;
  assign trans_id_o = alloc_ptr_r;

  //////////////////////////////
  // response side
  //////////////////////////////

  // only the oldest id may leave
  assign io_resp_v_o      = filled_r[deq_ptr_r];
  assign io_resp_o.header = header_r[deq_ptr_r];
  assign io_resp_o.data   = {{(bp_io_pkg::BP_DATA_WIDTH - mc_net_pkg::MC_DATA_WIDTH){1'b0}},
                             data_r[deq_ptr_r]};
  assign deq              = io_resp_v_o & io_resp_yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (issue)
      header_r[alloc_ptr_r] <= cmd_header_i;
    if (mc_return_v_i)
      data_r[mc_return_i.reg_id] <= mc_return_i.data;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      alloc_ptr_r <= '0;
      deq_ptr_r   <= '0;
      count_r     <= '0;
      filled_r    <= '0;
    end
    else
    begin
      if (issue)
        alloc_ptr_r <= alloc_ptr_r + 1'b1;
      if (deq)
        deq_ptr_r <= deq_ptr_r + 1'b1;

      if (issue && !deq)
        count_r <= count_r + 1'b1;
      else if (deq && !issue)
        count_r <= count_r - 1'b1;

      // a return never targets the id being drained
      if (deq)
        filled_r[deq_ptr_r] <= 1'b0;
      if (mc_return_v_i)
        filled_r[mc_return_i.reg_id] <= 1'b1;
    end
  end

endmodule

// ==== testbench/bp_mc_bridge_assert.sv ====
`timescale 1ns/1ps

module bp_mc_bridge_assert
  (
    input logic                                 clk_i,
    input logic                                 arst_n_i,
    input bp_io_pkg::bp_io_msg_s                head_msg_i,
    input bp_io_pkg::bp_io_msg_s                io_resp_o,
    input logic                                 io_resp_v_o,
    input logic                                 io_resp_yumi_i,
    input mc_net_pkg::mc_packet_s               mc_out_o,
    input logic                                 mc_out_v_o,
    input logic                                 mc_out_ready_i,
    input mc_net_pkg::mc_in_req_s               mc_in_i,
    input logic                                 mc_in_v_i,
    input logic                                 mc_in_yumi_o,
    input bp_io_pkg::bp_io_msg_s                io_cmd_o,
    input logic                                 io_cmd_v_o,
    input logic                                 io_cmd_yumi_i,
    input bp_io_pkg::bp_io_msg_s                io_resp_i,
    input logic                                 io_resp_v_i,
    input logic [mc_net_pkg::MC_DATA_WIDTH-1:0] mc_returning_data_o,
    input logic                                 mc_returning_v_o,
    input logic [mc_net_pkg::MC_X_WIDTH-1:0]    my_x_i,
    input logic [mc_net_pkg::MC_Y_WIDTH-1:0]    my_y_i
  );

  int          fail_count = 0;
  logic [39:0] cmd_addr;
  logic        cmd_rd;
  logic [3:0]  exp_mask;
  logic [31:0] ret_keep;
  logic [39:0] exp_in_addr;

  assign cmd_addr = head_msg_i.header.addr;
  assign cmd_rd   = (head_msg_i.header.msg_type == bp_io_pkg::e_uc_rd)
                    || (head_msg_i.header.msg_type == bp_io_pkg::e_rd);

  // byte lanes touched by a store
  assign exp_mask = (head_msg_i.header.size == bp_io_pkg::e_size_1) ? (4'h1 << cmd_addr[1:0])
                  : (head_msg_i.header.size == bp_io_pkg::e_size_2) ? (4'h3 << cmd_addr[1:0])
                  : (4'hf << cmd_addr[1:0]);

  assign ret_keep = (io_resp_i.header.size == bp_io_pkg::e_size_4) ? 32'hffff_ffff
                  : (io_resp_i.header.size == bp_io_pkg::e_size_2) ? 32'h0000_ffff
                  : 32'h0000_00ff;

  assign exp_in_addr = ((mc_in_i.addr[15:12] == 4'd1) ? bp_io_pkg::BP_CLINT_BASE
                                                      : bp_io_pkg::BP_CFG_BASE)
                       + {28'h0, mc_in_i.addr[11:0]};

  ///////////////////////////////
  // outbound routing
  ///////////////////////////////

  tile_route_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mc_out_v_o && cmd_addr[39:38] == 2'b11) |->
      (mc_out_o.dst_x == cmd_addr[26:20] && mc_out_o.dst_y == cmd_addr[33:27]
       && mc_out_o.addr == {10'h0, cmd_addr[19:2]}))
  else
  begin
    $error("tile packet has wrong destination or address");
    fail_count++;
  end

  vcache_route_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mc_out_v_o && cmd_addr[39:38] == 2'b10) |->
      (mc_out_o.dst_x == cmd_addr[36:30] && mc_out_o.dst_y == (cmd_addr[37] ? 7'd16 : 7'd7)
       && mc_out_o.addr == cmd_addr[29:2]))
  else
  begin
    $error("vcache packet has wrong destination or address");
    fail_count++;
  end

  host_route_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mc_out_v_o && !cmd_addr[39]) |->
      (mc_out_o.dst_x == 7'd0 && mc_out_o.dst_y == my_y_i - 7'd1
       && mc_out_o.addr == cmd_addr[29:2]))
  else
  begin
    $error("host packet has wrong destination or address");
    fail_count++;
  end

  src_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mc_out_v_o |-> (mc_out_o.src_x == my_x_i && mc_out_o.src_y == my_y_i))
  else
  begin
    $error("packet source is not this bridge");
    fail_count++;
  end

  ///////////////////////////////
  // operation encoding
  ///////////////////////////////

  load_enc_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mc_out_v_o && cmd_rd) |->
      (mc_out_o.op == mc_net_pkg::e_remote_load
       && mc_out_o.load_info == {head_msg_i.header.size == bp_io_pkg::e_size_1,
                                 head_msg_i.header.size == bp_io_pkg::e_size_2,
                                 cmd_addr[1:0]}))
  else
  begin
    $error("load packet has wrong op or load info");
    fail_count++;
  end

  store_enc_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mc_out_v_o && !cmd_rd) |->
      (mc_out_o.op == mc_net_pkg::e_remote_store && mc_out_o.mask == exp_mask
       && mc_out_o.payload == head_msg_i.data[31:0]))
  else
  begin
    $error("store packet has wrong op, mask or payload");
    fail_count++;
  end

  ///////////////////////////////
  // handshakes
  ///////////////////////////////

  out_hold_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mc_out_v_o && !mc_out_ready_i) |=> (mc_out_v_o && $stable(mc_out_o)))
  else
  begin
    $error("network packet changed while stalled");
    fail_count++;
  end

  resp_hold_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (io_resp_v_o && !io_resp_yumi_i) |=> (io_resp_v_o && $stable(io_resp_o)))
  else
  begin
    $error("processor response changed while stalled");
    fail_count++;
  end

  ///////////////////////////////
  // inbound path
  ///////////////////////////////

  inbound_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mc_in_v_i |->
      (io_cmd_v_o && mc_in_yumi_o == io_cmd_yumi_i && io_cmd_o.header.addr == exp_in_addr
       && io_cmd_o.header.msg_type == (mc_in_i.we ? bp_io_pkg::e_uc_wr : bp_io_pkg::e_uc_rd)
       && io_cmd_o.header.size == bp_io_pkg::e_size_4
       && io_cmd_o.data == {32'h0, mc_in_i.data}))
  else
  begin
    $error("inbound request converted wrong");
    fail_count++;
  end

  ret_size_chk: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    io_resp_v_i |->
      (mc_returning_v_o && mc_returning_data_o == (io_resp_i.data[31:0] & ret_keep)))
  else
  begin
    $error("returning data not cut to size");
    fail_count++;
  end

endmodule

bind bp_mc_bridge bp_mc_bridge_assert i_bp_mc_bridge_assert (.*, .head_msg_i(head_msg));

// ==== testbench/tb_bp_mc_bridge.sv ====
`timescale 1ns/1ps

module tb_bp_mc_bridge;

  localparam int NUM_CMDS = 48;
  localparam int TIMEOUT  = 400;

  logic                         clk;
  logic                         arst_n;
  bp_io_pkg::bp_io_msg_s        cmd_msg;
  logic                         cmd_v;
  logic                         cmd_ready;
  bp_io_pkg::bp_io_msg_s        resp_msg;
  logic                         resp_v;
  logic                         resp_yumi;
  mc_net_pkg::mc_packet_s       out_pkt;
  logic                         out_v;
  logic                         out_ready;
  mc_net_pkg::mc_return_s       ret_pkt;
  logic                         ret_v;
  mc_net_pkg::mc_in_req_s       in_req;
  logic                         in_v;
  logic                         in_yumi;
  bp_io_pkg::bp_io_msg_s        fwd_cmd;
  logic                         fwd_cmd_v;
  logic                         fwd_cmd_yumi;
  bp_io_pkg::bp_io_msg_s        fwd_resp;
  logic                         fwd_resp_v;
  logic [31:0]                  ret_data;
  logic                         ret_data_v;
  logic [6:0]                   my_x;
  logic [6:0]                   my_y;

  logic [31:0]                  lfsr_state = 32'h2563f6ee;
  // headers in command order
  bp_io_pkg::bp_io_header_s     exp_q[$];

  bp_mc_bridge i_bp_mc_bridge
  (
    .clk_i (clk), .arst_n_i (arst_n),
    .io_cmd_i (cmd_msg), .io_cmd_v_i (cmd_v), .io_cmd_ready_o (cmd_ready),
    .io_resp_o (resp_msg), .io_resp_v_o (resp_v), .io_resp_yumi_i (resp_yumi),
    .mc_out_o (out_pkt), .mc_out_v_o (out_v), .mc_out_ready_i (out_ready),
    .mc_return_i (ret_pkt), .mc_return_v_i (ret_v),
    .mc_in_i (in_req), .mc_in_v_i (in_v), .mc_in_yumi_o (in_yumi),
    .io_cmd_o (fwd_cmd), .io_cmd_v_o (fwd_cmd_v), .io_cmd_yumi_i (fwd_cmd_yumi),
    .io_resp_i (fwd_resp), .io_resp_v_i (fwd_resp_v),
    .mc_returning_data_o (ret_data), .mc_returning_v_o (ret_data_v),
    .my_x_i (my_x), .my_y_i (my_y)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ///////////////////////////////
  // helpers
  ///////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // model memory, keyed on word address bits shared by all regions
  function automatic logic [31:0] load_word(input logic [17:0] w);
    return {w[13:0], w} ^ 32'hc3a5_96e1;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic send_cmd();
    bp_io_pkg::bp_io_msg_s m;
    logic [31:0] r;
    logic [31:0] lo;
    int waited;
    r  = take_bits(12);
    lo = take_bits(32);
    m.header.msg_type = bp_io_pkg::bp_msg_type_e'(r[1:0]);
    m.header.size     = bp_io_pkg::bp_msg_size_e'(r[3:2]);
    m.header.addr     = {r[5:4], r[11:6], lo};
    m.data            = {take_bits(32), take_bits(32)};
    cmd_msg = m;
    cmd_v   = 1'b1;
    waited  = 0;
    while (!cmd_ready)
    begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT)
        fail_now("command FIFO never became ready");
    end
    exp_q.push_back(m.header);
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  ///////////////////////////////
  // network and processor models
  ///////////////////////////////

  task automatic run_network();
    logic [1:0]  ids[$];
    logic [31:0] datas[$];
    int          delays[$];
    int          start;
    int          pick;
    forever
    begin
      @(negedge clk);
      ret_v = 1'b0;
      for (int i = 0; i < delays.size(); i++)
        if (delays[i] > 0)
          delays[i]--;
      if (ids.size() != 0)
      begin
        start = int'(take_bits(2)) % ids.size();
        pick  = -1;
        for (int i = 0; i < ids.size(); i++)
          if (pick < 0 && delays[(start + i) % ids.size()] == 0)
            pick = (start + i) % ids.size();
        if (pick >= 0)
        begin
          ret_pkt.reg_id = ids[pick];
          ret_pkt.data   = datas[pick];
          ret_v          = 1'b1;
          ids.delete(pick);
          datas.delete(pick);
          delays.delete(pick);
        end
      end
      out_ready = (take_bits(2) != 0);
      if (out_v && out_ready)
      begin
        ids.push_back(out_pkt.reg_id);
        datas.push_back((out_pkt.op == mc_net_pkg::e_remote_load)
                        ? load_word(out_pkt.addr[17:0]) : 32'h0);
        delays.push_back(int'(take_bits(3)));
      end
    end
  endtask

  task automatic take_responses();
    bp_io_pkg::bp_io_header_s h;
    logic [63:0]              exp_data;
    forever
    begin
      @(negedge clk);
      resp_yumi = 1'b0;
      if (resp_v && take_bits(2) != 0)
      begin
        if (exp_q.size() == 0)
          fail_now("response arrived with no command outstanding");
        h = exp_q.pop_front();
        exp_data = ((h.msg_type == bp_io_pkg::e_uc_rd) || (h.msg_type == bp_io_pkg::e_rd))
                   ? {32'h0, load_word(h.addr[19:2])} : 64'h0;
        if (resp_msg.header !== h)
          fail_now($sformatf("Fail io_resp_o.header %h expected %h", resp_msg.header, h));
        if (resp_msg.data !== exp_data)
          fail_now($sformatf("Fail io_resp_o.data %h expected %h", resp_msg.data, exp_data));
        resp_yumi = 1'b1;
      end
    end
  endtask

  task automatic drive_inbound();
    logic [31:0] r;
    forever
    begin
      @(negedge clk);
      r = take_bits(20);
      in_v                   = r[0];
      in_req.we              = r[1];
      // dev field spans cfg, clint and unknown ids
      in_req.addr            = {12'h0, 2'b00, r[3:2], r[15:4]};
      in_req.data            = take_bits(32);
      fwd_cmd_yumi           = r[16] & r[0];
      fwd_resp_v             = r[17];
      fwd_resp.header.size   = bp_io_pkg::bp_msg_size_e'(r[19:18]);
      fwd_resp.data          = {take_bits(32), take_bits(32)};
    end
  endtask

  task automatic watch_assertions();
    forever
    begin
      @(negedge clk);
      if (i_bp_mc_bridge.i_bp_mc_bridge_assert.fail_count != 0)
        fail_now("a bound assertion failed");
    end
  endtask

  ///////////////////////////////
  // main sequence
  ///////////////////////////////

  initial
  begin
    int waited;
    arst_n       = 1'b0;
    cmd_msg      = '0;
    cmd_v        = 1'b0;
    resp_yumi    = 1'b0;
    out_ready    = 1'b0;
    ret_pkt      = '0;
    ret_v        = 1'b0;
    in_req       = '0;
    in_v         = 1'b0;
    fwd_cmd_yumi = 1'b0;
    fwd_resp     = '0;
    fwd_resp_v   = 1'b0;
    my_x         = 7'd3;
    my_y         = 7'd9;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    fork
      run_network();
      take_responses();
      drive_inbound();
      watch_assertions();
    join_none
    for (int n = 0; n < NUM_CMDS; n++)
    begin
      send_cmd();
      if (take_bits(2) == 0)
        repeat (3) @(negedge clk);
    end
    waited = 0;
    while (exp_q.size() != 0)
    begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT)
        fail_now("outstanding responses never drained");
    end
    @(negedge clk);
    if (i_bp_mc_bridge.i_bp_mc_bridge_assert.fail_count != 0)
      fail_now("a bound assertion failed");
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule
